// File: hdl/nes_bus_pkg.sv
// Bus request structs, sprite DMA state and decode region enums, fixed register addresses
package nes_bus_pkg;

	// Fixed register addresses on the CPU bus
	localparam logic [15:0] OAM_DATA_ADDR   = 16'h2004; // Sprite memory data port
	localparam logic [15:0] APU_BASE_ADDR   = 16'h4000; // First audio register
	localparam logic [15:0] OAM_DMA_ADDR    = 16'h4014; // Write here starts sprite DMA
	localparam logic [15:0] APU_STATUS_ADDR = 16'h4015; // Audio channel status
	localparam logic [15:0] JOY1_ADDR       = 16'h4016; // Pad 1 data, strobe on write
	localparam logic [15:0] JOY2_ADDR       = 16'h4017; // Pad 2 data

	// CPU request for one CPU cycle
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;  // Write data
		logic        rnw;   // 1 = read
	} cpu_bus_t;

	// Effective bus after master select
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        read;
		logic        write;
	} bus_t;

	// External memory access
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        read;
		logic        write;
	} mem_req_t;

	// Picture unit register port, eight registers mirrored over the window
	typedef struct packed {
		logic [2:0] idx;
		logic [7:0] data;
		logic       read;
		logic       write;
	} ppu_reg_t;

	typedef enum logic [1:0] {
		SPR_IDLE,   // No sprite transfer
		SPR_ALIGN,  // Triggered, waiting for an odd cycle
		SPR_RUN     // Read/write pairs in progress
	} spr_state_t;

	typedef enum logic [2:0] {
		REG_MEM, REG_PPU, REG_APU, REG_JOY1, REG_JOY2, REG_APU_STATUS
	} bus_region_t;

endpackage

// File: hdl/clock_enables.sv
// Master clock dividers for the CPU and picture unit enables and the odd CPU cycle flag
`timescale 1ns/1ps

module clock_enables #(
	parameter int CPU_DIV = 12,  // Master clocks per CPU cycle
	parameter int PPU_DIV = 4    // Master clocks per picture unit dot
) (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,
	output logic ppu_ce,
	output logic odd_cycle
);
	localparam int CPU_W = $clog2(CPU_DIV);
	localparam int PPU_W = $clog2(PPU_DIV);
	localparam logic [CPU_W-1:0] CPU_LAST = CPU_W'(CPU_DIV - 1);
	localparam logic [PPU_W-1:0] PPU_LAST = PPU_W'(PPU_DIV - 1);

	logic [CPU_W-1:0] cpu_cnt;
	logic [PPU_W-1:0] ppu_cnt;

	// Enables fire on the last count, so the first cpu_ce lands on clock CPU_DIV
	assign cpu_ce = (cpu_cnt == CPU_LAST);
	assign ppu_ce = (ppu_cnt == PPU_LAST);

	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_cnt   <= '0;
			ppu_cnt   <= '0;
			odd_cycle <= 1'b0; // First CPU cycle is even
		end else begin
			cpu_cnt <= cpu_ce ? '0 : cpu_cnt + 1'b1;
			ppu_cnt <= ppu_ce ? '0 : ppu_cnt + 1'b1;

			// Parity of the CPU cycle now running
			if (cpu_ce)
				odd_cycle <= ~odd_cycle;
		end
	end

	// Both counters restart together, so ppu_ce lines up with cpu_ce when
	// CPU_DIV is a multiple of PPU_DIV (three dots per CPU cycle by default)

endmodule

// File: hdl/dma_controller.sv
// Sprite and sample channel DMA sequencer with CPU/DMA bus master select
`timescale 1ns/1ps

module dma_controller
	import nes_bus_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        cpu_ce,
	input  logic        odd_cycle,       // Parity of the current CPU cycle
	input  logic        sprite_trigger,  // Write to the sprite DMA register
	input  cpu_bus_t    cpu,
	input  logic        dmc_req_valid,
	input  logic [15:0] dmc_addr,        // Held until dmc_ack
	input  logic [7:0]  bus_din,         // Byte returned by the decoder
	output bus_t        bus,
	output logic        dmc_ack,
	output logic        pause_cpu
);
	spr_state_t  spr_state;
	logic        dmc_pend;   // Sample fetch waiting for an even cycle
	logic        rd_done;    // Sprite read of this pair really happened
	logic [15:0] src_addr;   // Page in the high byte, index in the low byte
	logic [7:0]  spr_byte;   // Byte on its way to sprite memory
	logic        dmc_fetch;
	logic        spr_run;
	logic        dma_own;
	logic [8:0]  next_lo;

	// Sample fetch only ever lands on an even cycle
	assign dmc_fetch = dmc_pend && !odd_cycle;
	assign spr_run   = (spr_state == SPR_RUN);
	assign dma_own   = dmc_fetch || spr_run;
	assign dmc_ack   = dmc_fetch && cpu_ce; // One clock, at the end of the fetch cycle
	assign next_lo   = {1'b0, src_addr[7:0]} + 9'd1; // Bit 8 marks the last pair

	// CPU stalls while any DMA is asked for or running
	assign pause_cpu = dmc_req_valid || dmc_pend || (spr_state != SPR_IDLE);

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= SPR_IDLE;
			dmc_pend  <= 1'b0;
			rd_done   <= 1'b0;
		end else if (cpu_ce) begin
			if (dmc_fetch)
				dmc_pend <= 1'b0;  // Served in this cycle
			else if (dmc_req_valid)
				dmc_pend <= 1'b1;

			case (spr_state)
				SPR_IDLE:  if (sprite_trigger) spr_state <= SPR_ALIGN;
				SPR_ALIGN: if (odd_cycle) spr_state <= SPR_RUN; // Reads start on the next even
				SPR_RUN:   if (odd_cycle && rd_done && next_lo[8]) spr_state <= SPR_IDLE;
				default:   spr_state <= SPR_IDLE;
			endcase

			// A sample fetch steals the even read, the odd slot after it idles
			rd_done <= spr_run && !odd_cycle && !dmc_fetch;
		end
	end

	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (sprite_trigger && !spr_run)
				src_addr <= {cpu.dout, 8'h00};  // Page number written by the CPU
			else if (spr_run && odd_cycle && rd_done)
				src_addr[7:0] <= next_lo[7:0];  // Step only after a completed pair
			if (spr_run && !odd_cycle && !dmc_fetch)
				spr_byte <= bus_din;
		end
	end

	// Master select
	always_comb begin
		if (!dma_own) begin
			bus = '{addr: cpu.addr, data: cpu.dout, read: cpu.rnw, write: !cpu.rnw};
		end else if (dmc_fetch) begin
			bus = '{addr: dmc_addr, data: 8'h00, read: 1'b1, write: 1'b0};
		end else begin
			bus.addr  = odd_cycle ? OAM_DATA_ADDR : src_addr;
			bus.data  = spr_byte;
			bus.read  = !odd_cycle;
			bus.write = odd_cycle && rd_done;  // Idle slot when the read was lost
		end
	end

endmodule

// File: hdl/bus_decoder.sv
// Address region decode, joypad strobe and clocks, open bus latch and CPU read data mux
`timescale 1ns/1ps

module bus_decoder
	import nes_bus_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       cpu_ce,
	input  bus_t       bus,
	input  logic [7:0] mem_din,
	input  logic [7:0] ppu_din,
	input  logic [7:0] apu_status,
	input  logic [3:0] joypad_data,   // Bit 0 pad 1, bits 3..1 pad 2 port
	output mem_req_t   mem,
	output ppu_reg_t   ppu_reg,
	output logic       joypad_strobe,
	output logic [1:0] joypad_clock,
	output logic       sprite_trigger,
	output logic [7:0] bus_din
);
	bus_region_t region;
	logic [7:0]  open_bus;  // Last byte the CPU read

	always_comb begin
		if (bus.addr[15:13] == 3'b001)
			region = REG_PPU;             // 0x2000-0x3FFF, mirrored every 8
		else if (bus.addr == APU_STATUS_ADDR)
			region = REG_APU_STATUS;
		else if (bus.addr == JOY1_ADDR)
			region = REG_JOY1;
		else if (bus.addr == JOY2_ADDR)
			region = REG_JOY2;
		else if (bus.addr >= APU_BASE_ADDR && bus.addr < JOY1_ADDR)
			region = REG_APU;             // Includes the sprite DMA register
		else
			region = REG_MEM;
	end

	// Memory gets everything outside the register windows
	assign mem.addr  = bus.addr;
	assign mem.data  = bus.data;
	assign mem.read  = bus.read && (region == REG_MEM);
	assign mem.write = bus.write && (region == REG_MEM);

	assign ppu_reg.idx   = bus.addr[2:0];
	assign ppu_reg.data  = bus.data;
	assign ppu_reg.read  = bus.read && (region == REG_PPU);
	assign ppu_reg.write = bus.write && (region == REG_PPU);

	assign sprite_trigger = bus.write && (bus.addr == OAM_DMA_ADDR);

	// Pads shift on reads of their own port
	assign joypad_clock = {bus.read && (region == REG_JOY2), bus.read && (region == REG_JOY1)};

	always_comb begin
		case (region)
			REG_JOY1:       bus_din = {open_bus[7:5], 4'b0000, joypad_data[0]};
			REG_JOY2:       bus_din = {open_bus[7:5], joypad_data[3:2], 2'b00, joypad_data[1]};
			REG_APU_STATUS: bus_din = apu_status;
			REG_APU:        bus_din = open_bus;  // Write-only audio registers
			REG_PPU:        bus_din = ppu_din;
			default:        bus_din = mem_din;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			joypad_strobe <= 1'b0;
			open_bus      <= 8'h00;
		end else if (cpu_ce) begin
			if (bus.write && region == REG_JOY1)
				joypad_strobe <= bus.data[0];  // 1 reloads the pads, 0 lets them shift
			if (bus.read)
				open_bus <= bus_din;
		end
	end

endmodule

// File: hdl/nes_bus_top.sv
// Console bus core top level with clock enables, DMA controller and address decoder
`timescale 1ns/1ps

module nes_bus_top
	import nes_bus_pkg::*;
#(
	parameter int CPU_DIV = 12,
	parameter int PPU_DIV = 4
) (
	input  logic        clk,
	input  logic        reset,
	input  cpu_bus_t    cpu,
	input  logic [7:0]  mem_din,
	input  logic [7:0]  ppu_din,
	input  logic [7:0]  apu_status,
	input  logic [3:0]  joypad_data,
	input  logic        dmc_req_valid,
	input  logic [15:0] dmc_addr,
	output logic        cpu_ce,
	output logic        ppu_ce,
	output logic [7:0]  cpu_din,
	output logic        pause_cpu,
	output mem_req_t    mem,
	output ppu_reg_t    ppu_reg,
	output logic        joypad_strobe,
	output logic [1:0]  joypad_clock,
	output logic        dmc_ack
);
	logic       odd_cycle;
	logic       sprite_trigger;
	bus_t       bus;       // Bus after master select
	logic [7:0] bus_din;   // Read data back to CPU and DMA

	assign cpu_din = bus_din;

	clock_enables #(
		.CPU_DIV (CPU_DIV),
		.PPU_DIV (PPU_DIV)
	) i_clock_enables (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.ppu_ce    (ppu_ce),
		.odd_cycle (odd_cycle)
	);

	dma_controller i_dma_controller (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.odd_cycle      (odd_cycle),
		.sprite_trigger (sprite_trigger),
		.cpu            (cpu),
		.dmc_req_valid  (dmc_req_valid),
		.dmc_addr       (dmc_addr),
		.bus_din        (bus_din),
		.bus            (bus),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu)
	);

	bus_decoder i_bus_decoder (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.bus            (bus),
		.mem_din        (mem_din),
		.ppu_din        (ppu_din),
		.apu_status     (apu_status),
		.joypad_data    (joypad_data),
		.mem            (mem),
		.ppu_reg        (ppu_reg),
		.joypad_strobe  (joypad_strobe),
		.joypad_clock   (joypad_clock),
		.sprite_trigger (sprite_trigger),
		.bus_din        (bus_din)
	);

endmodule

// File: verification/nes_bus_sva.sv
// Concurrent assertions on the DMC handshake, memory strobes, CPU enable spacing and bus ownership
`timescale 1ns/1ps

module nes_bus_sva
	import nes_bus_pkg::*;
(
	input logic     clk,
	input logic     reset,
	input logic     cpu_ce,
	input logic     odd_cycle,
	input logic     pause_cpu,
	input logic     dmc_ack,
	input logic     dmc_req_valid,
	input cpu_bus_t cpu,
	input bus_t     bus,
	input mem_req_t mem
);
	logic [10:0] ce_hist;   // cpu_ce over the last 11 clocks
	logic        dma_owns;

	// Bus only strays from the CPU request while a DMA holds it
	assign dma_owns = (bus.addr != cpu.addr) || (bus.read != cpu.rnw) || (bus.write == cpu.rnw);

	always @(posedge clk) begin
		if (reset)
			ce_hist <= '0;
		else
			ce_hist <= {ce_hist[9:0], cpu_ce};
	end

	dmc_ack_even: assert property (@(posedge clk) disable iff (reset)
		dmc_ack |-> dmc_req_valid && !odd_cycle)
		else $error("dmc_ack without a request or in an odd CPU cycle");

	mem_one_strobe: assert property (@(posedge clk) disable iff (reset)
		!(mem.read && mem.write))
		else $error("mem read and write high together");

	ce_quiet_before: assert property (@(posedge clk) disable iff (reset)
		cpu_ce |-> ce_hist == '0)
		else $error("cpu_ce closer than 12 clocks to the previous one");

	ce_next: assert property (@(posedge clk) disable iff (reset)
		cpu_ce |-> ##12 cpu_ce)
		else $error("cpu_ce missing 12 clocks after the previous one");

	dma_paused: assert property (@(posedge clk) disable iff (reset)
		dma_owns |-> pause_cpu)
		else $error("DMA drives the bus while the CPU is not paused");

endmodule

// File: verification/nes_bus_tb.sv
// Console bus core testbench with CPU, memory and joypad models, stimulus table and checks
`timescale 1ns/1ps

module nes_bus_tb
	import nes_bus_pkg::*;
();
	typedef enum logic [1:0] {OP_RD, OP_WR, OP_SPR, OP_DMC} op_t;

	// Sprite rows carry the page in data and a mid-transfer DMC address in addr (0 = none)
	typedef struct packed {
		op_t         op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [3:0]  joy;
		logic [7:0]  ppu;
		logic [7:0]  apu;
		logic [7:0]  want;  // Expected cpu_din on reads
	} row_t;

	localparam int N_ROWS      = 20;
	localparam int CYCLE_LIMIT = 12 * (N_ROWS + 4 * 530) * 2;

	logic        clk = 1'b0;
	logic        reset;
	cpu_bus_t    cpu;
	logic [7:0]  mem_din;
	logic [7:0]  ppu_din;
	logic [7:0]  apu_status;
	logic [3:0]  joypad_data;
	logic        dmc_req_valid;
	logic [15:0] dmc_addr;
	logic        cpu_ce;
	logic        ppu_ce;
	logic [7:0]  cpu_din;
	logic        pause_cpu;
	mem_req_t    mem;
	ppu_reg_t    ppu_reg;
	logic        joypad_strobe;
	logic [1:0]  joypad_clock;
	logic        dmc_ack;

	row_t        rows [N_ROWS];
	logic [7:0]  mem_wr [16];    // Memory writes by low address nibble
	logic [31:0] lcg_state;
	int          errors = 0;
	int          checks = 0;
	int          wr_count = 0;   // Memory writes seen
	int          ack_count = 0;  // dmc_ack pulses seen
	int          clocks = 0;
	int          since_ce = 0;
	int          ppu_since_ce = 0;
	bit          ce_seen = 1'b0;

	// Memory model is low byte XOR high byte XOR 0x5A
	function automatic logic [7:0] mem_model(input logic [15:0] a);
		return a[7:0] ^ a[15:8] ^ 8'h5A;
	endfunction

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic row_t make_row(input op_t op, input logic [15:0] addr,
			input logic [7:0] data, input logic [3:0] joy, input logic [7:0] ppu,
			input logic [7:0] apu, input logic [7:0] want);
		return '{op, addr, data, joy, ppu, apu, want};
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	assign mem_din = mem_model(mem.addr); // Memory answers in the same cycle

	nes_bus_top #(.CPU_DIV(12), .PPU_DIV(4)) i_nes_bus_top (.*);

	bind nes_bus_top nes_bus_sva i_nes_bus_sva (.*);

	always #5 clk = ~clk;

	// Hang guard
	always @(posedge clk) begin
		clocks++;
		if (clocks >= CYCLE_LIMIT) begin
			$display("Timeout, the run did not finish within %0d clocks", CYCLE_LIMIT);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// Enable cadence, memory write log and ack count sampled mid-cycle
	always @(negedge clk) begin
		if (!reset) begin
			since_ce++;
			if (ppu_ce)
				ppu_since_ce++;
			if (cpu_ce) begin
				if (ce_seen) begin
					check("clocks between cpu_ce", 12, since_ce);
					check("ppu_ce per CPU cycle", 3, ppu_since_ce);
				end
				ce_seen      = 1'b1;
				since_ce     = 0;
				ppu_since_ce = 0;
				if (mem.write) begin
					mem_wr[mem.addr[3:0]] = mem.data;
					wr_count++;
				end
				if (dmc_ack)
					ack_count++;
			end
		end
	end

	// Stalls until the CPU's held request goes through at cpu_ce
	task automatic wait_taken();
		do @(negedge clk); while (!(cpu_ce && !pause_cpu));
	endtask

	task automatic check_dmc_fetch(input logic [15:0] a);
		check("mem.read on DMC fetch", 1, mem.read);
		check("mem.addr on DMC fetch", a, mem.addr);
		check("cpu_din on DMC fetch", mem_model(a), cpu_din);
	endtask

	task automatic check_read(input row_t r);
		check("cpu_din", r.want, cpu_din);
		if (r.addr[15:13] == 3'b001) begin
			check("ppu_reg.read", 1, ppu_reg.read);
			check("ppu_reg.idx", r.addr[2:0], ppu_reg.idx);
		end
		if (r.addr[15])
			check("mem.read", 1, mem.read);
		check("joypad_clock", {r.addr == JOY2_ADDR, r.addr == JOY1_ADDR}, joypad_clock);
	endtask

	task automatic sprite_dma(input logic [7:0] page, input logic [15:0] dmc_a);
		int         rd_n;
		int         wr_n;
		int         acks;
		bit         done;
		logic [7:0] last_rd;
		rd_n    = 0;
		wr_n    = 0;
		acks    = 0;
		done    = 1'b0;
		last_rd = 8'h00;
		cpu = '{addr: OAM_DMA_ADDR, dout: page, rnw: 1'b0};
		wait_taken();
		@(posedge clk);
		#1;
		check("pause_cpu after DMA trigger", 1, pause_cpu);
		cpu = '{addr: APU_BASE_ADDR, dout: 8'h00, rnw: 1'b1}; // Held while stalled
		while (!done) begin
			@(negedge clk);
			if (cpu_ce) begin
				if (!pause_cpu) begin
					done = 1'b1;
				end else if (dmc_ack) begin
					acks++;
					check_dmc_fetch(dmc_a);
				end else if (mem.read) begin
					check("sprite read addr", {page, 8'(rd_n)}, mem.addr);
					check("sprite read data", mem_model({page, 8'(rd_n)}), cpu_din);
					check("sprite pair order", wr_n, rd_n); // Previous pair complete
					last_rd = mem_model({page, 8'(rd_n)});
					rd_n++;
				end else if (ppu_reg.write) begin
					check("sprite write idx", 4, ppu_reg.idx);
					check("sprite write data", last_rd, ppu_reg.data);
					check("sprite pair order", wr_n + 1, rd_n);
					wr_n++;
				end
				@(posedge clk);
				#1;
				if (dmc_a != 16'h0000 && acks == 0 && rd_n >= 100) begin
					dmc_addr      = dmc_a;  // Sample fetch lands mid-transfer
					dmc_req_valid = 1'b1;
				end
				if (acks != 0)
					dmc_req_valid = 1'b0;
			end
		end
		check("sprite reads", 256, rd_n);
		check("sprite writes", 256, wr_n);
		check("DMC acks during sprite DMA", (dmc_a != 16'h0000) ? 1 : 0, acks);
	endtask

	task automatic dmc_fetch_idle(input logic [15:0] a);
		int acks;
		bit done;
		acks = 0;
		done = 1'b0;
		cpu           = '{addr: APU_BASE_ADDR, dout: 8'h00, rnw: 1'b1};
		dmc_addr      = a;
		dmc_req_valid = 1'b1;
		while (!done) begin
			@(negedge clk);
			if (cpu_ce) begin
				if (dmc_ack) begin
					acks++;
					check_dmc_fetch(a);
				end else if (!pause_cpu) begin
					done = 1'b1;
				end
				@(posedge clk);
				#1;
				if (acks != 0)
					dmc_req_valid = 1'b0;  // Request ends after its ack
			end
		end
		check("DMC acks on idle bus", 1, acks);
	endtask

	task automatic apply_row(input row_t r);
		joypad_data = r.joy;
		ppu_din     = r.ppu;
		apu_status  = r.apu;
		case (r.op)
			OP_RD, OP_WR: begin
				cpu = '{addr: r.addr, dout: r.data, rnw: (r.op == OP_RD)};
				wait_taken();
				if (r.op == OP_RD)
					check_read(r);
				@(posedge clk);
				#1;
				if (r.op == OP_WR && r.addr == JOY1_ADDR)
					check("joypad_strobe", r.data[0], joypad_strobe);
				if (r.op == OP_WR && r.addr[15])
					check("memory write data", r.data, mem_wr[r.addr[3:0]]);
			end
			OP_SPR:  sprite_dma(r.data, r.addr);
			default: dmc_fetch_idle(r.addr);
		endcase
	endtask

	task automatic build_table();
		logic [31:0] r;
		logic [7:0]  page1;
		logic [7:0]  page2;
		logic [15:0] dmc1;
		logic [15:0] dmc2;
		r     = lcg_next();
		page1 = {1'b1, r[22:16]};  // Upper half is plain memory
		r     = lcg_next();
		page2 = {1'b1, r[22:16]};
		r     = lcg_next();
		dmc1  = {1'b1, r[30:16]};
		r     = lcg_next();
		dmc2  = {1'b1, r[30:16]};
		rows[0]  = make_row(OP_RD, 16'h8000, 8'h00, 4'h0, 8'h00, 8'h00, mem_model(16'h8000));
		rows[1]  = make_row(OP_RD, 16'h2002, 8'h00, 4'h0, 8'h3C, 8'h00, 8'h3C);
		rows[2]  = make_row(OP_RD, 16'h4015, 8'h00, 4'h0, 8'h00, 8'h9C, 8'h9C);
		rows[3]  = make_row(OP_RD, 16'h4000, 8'h00, 4'h0, 8'h00, 8'h00, 8'h9C); // Open bus
		rows[4]  = make_row(OP_WR, 16'h4016, 8'h01, 4'h0, 8'h00, 8'h00, 8'h00);
		rows[5]  = make_row(OP_WR, 16'h4016, 8'h00, 4'h0, 8'h00, 8'h00, 8'h00);
		rows[6]  = make_row(OP_RD, 16'h2002, 8'h00, 4'h0, 8'hE5, 8'h00, 8'hE5);
		rows[7]  = make_row(OP_RD, 16'h4016, 8'h00, 4'hB, 8'h00, 8'h00, 8'hE1); // 111 0000 1
		rows[8]  = make_row(OP_RD, 16'h4017, 8'h00, 4'h6, 8'h00, 8'h00, 8'hE9); // 111 01 00 1
		rows[9]  = make_row(OP_RD, 16'h4017, 8'h00, 4'h8, 8'h00, 8'h00, 8'hF0); // 111 10 00 0
		rows[10] = make_row(OP_RD, 16'h2002, 8'h00, 4'h0, 8'h1F, 8'h00, 8'h1F);
		rows[11] = make_row(OP_RD, 16'h4016, 8'h00, 4'h1, 8'h00, 8'h00, 8'h01); // 000 0000 1
		rows[12] = make_row(OP_SPR, 16'h0000, page1, 4'h0, 8'h00, 8'h00, 8'h00);
		rows[13] = make_row(OP_RD, 16'h8000, 8'h00, 4'h0, 8'h00, 8'h00, mem_model(16'h8000));
		rows[14] = make_row(OP_DMC, dmc1, 8'h00, 4'h0, 8'h00, 8'h00, 8'h00);
		rows[15] = make_row(OP_RD, 16'h8123, 8'h00, 4'h0, 8'h00, 8'h00, mem_model(16'h8123));
		rows[16] = make_row(OP_WR, 16'h8005, 8'h77, 4'h0, 8'h00, 8'h00, 8'h00);
		rows[17] = make_row(OP_SPR, dmc2, page2, 4'h0, 8'h00, 8'h00, 8'h00);
		rows[18] = make_row(OP_RD, 16'h2007, 8'h00, 4'h0, 8'h42, 8'h00, 8'h42);
		rows[19] = make_row(OP_RD, 16'h4000, 8'h00, 4'h0, 8'h00, 8'h00, 8'h42);
	endtask

	initial begin
		lcg_state     = 32'hbbe9_380e;
		reset         = 1'b1;
		cpu           = '{addr: APU_BASE_ADDR, dout: 8'h00, rnw: 1'b1};
		ppu_din       = 8'h00;
		apu_status    = 8'h00;
		joypad_data   = 4'h0;
		dmc_req_valid = 1'b0;
		dmc_addr      = 16'h0000;
		foreach (mem_wr[i])
			mem_wr[i] = 8'h00;
		build_table();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int i = 0; i < N_ROWS; i++)
			apply_row(rows[i]);
		check("dmc_ack total", 2, ack_count);
		check("memory write total", 1, wr_count);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: all.f
hdl/nes_bus_pkg.sv
hdl/clock_enables.sv
hdl/dma_controller.sv
hdl/bus_decoder.sv
hdl/nes_bus_top.sv
verification/nes_bus_sva.sv
verification/nes_bus_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the bus core testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module nes_bus_tb -f all.f -o nes_bus_sim

./obj_dir/nes_bus_sim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
exit 0
